// ==== hdl/exec_defs.svh ====
`ifndef EXEC_DEFS_SVH
`define EXEC_DEFS_SVH

// Datapath width
`define XLEN 32

// Reorder-buffer tag width
`define ROB_IDX_W 4

// Station depths
`define ALU_RS_SIZE 4
`define BR_RS_SIZE 2

`endif

// ==== hdl/exec_pkg.sv ====
`default_nettype none

package exec_pkg;

	// Target station of a dispatched micro-op
	typedef enum logic {
		UNIT_ALU = 1'b0,
		UNIT_BR  = 1'b1
	} unit_e;

	// ALU ops in the low half, branch compares above
	typedef enum logic [3:0] {
		OP_ADD = 4'd0,
		OP_SUB = 4'd1,
		OP_AND = 4'd2,
		OP_OR  = 4'd3,
		OP_XOR = 4'd4,
		OP_SLL = 4'd5,
		OP_SRL = 4'd6,
		OP_SLT = 4'd7,
		OP_BEQ = 4'd8,
		OP_BNE = 4'd9,
		OP_BLT = 4'd10,
		OP_BGE = 4'd11
	} op_e;

endpackage

`default_nettype wire

// ==== hdl/operand_capture.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "exec_defs.svh"

module operand_capture (
	input  logic [1:0]                 src_ready_i,
	input  logic [1:0][`XLEN-1:0]      src_i,
	input  logic [1:0]                 rob_rvalid_i,
	input  logic [1:0][`XLEN-1:0]      rob_rdata_i,
	input  logic                       cdb_valid_i,
	input  logic [`ROB_IDX_W-1:0]      cdb_tag_i,
	input  logic [`XLEN-1:0]           cdb_data_i,
	output logic [1:0][`ROB_IDX_W-1:0] rob_raddr_o,
	output logic [1:0]                 src_ready_o,
	output logic [1:0][`XLEN-1:0]      src_o
);

	// Tag sits in the low bits of a waiting source
	for (genvar i = 0; i < 2; i++) begin : gen_raddr
		assign rob_raddr_o[i] = src_i[i][`ROB_IDX_W-1:0];
	end

	always_comb begin
		src_ready_o = src_ready_i;
		src_o = src_i;
		for (int i = 0; i < 2; i++) begin
			if (!src_ready_i[i]) begin
				// ROB value wins over the bypass
				if (rob_rvalid_i[i]) begin
					src_ready_o[i] = 1'b1;
					src_o[i] = rob_rdata_i[i];
				end else if (cdb_valid_i && cdb_tag_i == src_i[i][`ROB_IDX_W-1:0]) begin
					src_ready_o[i] = 1'b1;
					src_o[i] = cdb_data_i;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/alu_rs.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "exec_defs.svh"

module alu_rs (
	input  logic                      clk,
	input  logic                      rst_i,
	input  logic                      flush_i,
	input  logic                      wr_i,
	input  exec_pkg::op_e             op_i,
	input  logic [`ROB_IDX_W-1:0]     tag_i,
	input  logic [1:0]                src_ready_i,
	input  logic [1:0][`XLEN-1:0]     src_i,
	input  logic                      cdb_valid_i,
	input  logic [`ROB_IDX_W-1:0]     cdb_tag_i,
	input  logic [`XLEN-1:0]          cdb_data_i,
	input  logic                      res_ack_i,
	output logic                      ready_o,
	output logic                      res_req_o,
	output logic [`ROB_IDX_W-1:0]     res_tag_o,
	output logic [`XLEN-1:0]          res_data_o
);

	localparam int N = `ALU_RS_SIZE;
	localparam int IDX_W = $clog2(N);
	localparam int SH_W = $clog2(`XLEN);

	logic [N-1:0]                 ent_valid;
	logic [N-1:0][1:0]            ent_rdy, ent_rdy_w;
	logic [N-1:0][1:0][`XLEN-1:0] ent_src, ent_src_w;
	exec_pkg::op_e                ent_op [N];
	logic [`ROB_IDX_W-1:0]        ent_tag [N];
	// Count of younger valid entries, so the oldest has the largest value
	logic [IDX_W-1:0]             ent_age [N];

	logic             free_found, sel_found, wr_en, issue;
	logic [IDX_W-1:0] free_idx, sel_idx;
	logic [`XLEN-1:0] sel_a, sel_b, alu_res;

	// CDB wakeup, also seen by select in the same cycle
	always_comb begin
		ent_rdy_w = ent_rdy;
		ent_src_w = ent_src;
		for (int i = 0; i < N; i++) begin
			for (int j = 0; j < 2; j++) begin
				if (!ent_rdy[i][j] && cdb_valid_i &&
						ent_src[i][j][`ROB_IDX_W-1:0] == cdb_tag_i) begin
					ent_rdy_w[i][j] = 1'b1;
					ent_src_w[i][j] = cdb_data_i;
				end
			end
		end
	end

	always_comb begin
		free_found = 1'b0;
		free_idx = '0;
		for (int i = N - 1; i >= 0; i--) begin
			if (!ent_valid[i]) begin
				free_found = 1'b1;
				free_idx = IDX_W'(i);
			end
		end
	end

	// Oldest entry with both sources ready
	always_comb begin
		sel_found = 1'b0;
		sel_idx = '0;
		for (int i = 0; i < N; i++) begin
			if (ent_valid[i] && (&ent_rdy_w[i]) &&
					(!sel_found || ent_age[i] > ent_age[sel_idx])) begin
				sel_found = 1'b1;
				sel_idx = IDX_W'(i);
			end
		end
	end

	assign ready_o = free_found;
	assign wr_en = wr_i && free_found && !flush_i;
	assign issue = sel_found && (!res_req_o || res_ack_i);
	assign sel_a = ent_src_w[sel_idx][0];
	assign sel_b = ent_src_w[sel_idx][1];

	always_comb begin
		case (ent_op[sel_idx])
			exec_pkg::OP_ADD: alu_res = sel_a + sel_b;
			exec_pkg::OP_SUB: alu_res = sel_a - sel_b;
			exec_pkg::OP_AND: alu_res = sel_a & sel_b;
			exec_pkg::OP_OR:  alu_res = sel_a | sel_b;
			exec_pkg::OP_XOR: alu_res = sel_a ^ sel_b;
			exec_pkg::OP_SLL: alu_res = sel_a << sel_b[SH_W-1:0];
			exec_pkg::OP_SRL: alu_res = sel_a >> sel_b[SH_W-1:0];
			exec_pkg::OP_SLT: alu_res = `XLEN'($signed(sel_a) < $signed(sel_b));
			default:          alu_res = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst_i || flush_i) begin
			ent_valid <= '0;
			res_req_o <= 1'b0;
		end else begin
			if (issue)
				ent_valid[sel_idx] <= 1'b0;
			if (wr_en)
				ent_valid[free_idx] <= 1'b1;
			if (issue)
				res_req_o <= 1'b1;
			else if (res_ack_i)
				res_req_o <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		ent_rdy <= ent_rdy_w;
		ent_src <= ent_src_w;
		for (int i = 0; i < N; i++) begin
			if (ent_valid[i])
				ent_age[i] <= ent_age[i] + IDX_W'(wr_en)
					- IDX_W'(issue && ent_age[i] > ent_age[sel_idx]);
		end
		if (wr_en) begin
			ent_op[free_idx] <= op_i;
			ent_tag[free_idx] <= tag_i;
			ent_rdy[free_idx] <= src_ready_i;
			ent_src[free_idx] <= src_i;
			ent_age[free_idx] <= '0;
		end
		if (issue) begin
			res_tag_o <= ent_tag[sel_idx];
			res_data_o <= alu_res;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/branch_rs.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "exec_defs.svh"

module branch_rs (
	input  logic                      clk,
	input  logic                      rst_i,
	input  logic                      flush_i,
	input  logic                      wr_i,
	input  exec_pkg::op_e             op_i,
	input  logic [`ROB_IDX_W-1:0]     tag_i,
	input  logic [`XLEN-1:0]          pc_i,
	input  logic [`XLEN-1:0]          imm_i,
	input  logic [1:0]                src_ready_i,
	input  logic [1:0][`XLEN-1:0]     src_i,
	input  logic                      cdb_valid_i,
	input  logic [`ROB_IDX_W-1:0]     cdb_tag_i,
	input  logic [`XLEN-1:0]          cdb_data_i,
	input  logic                      res_ack_i,
	output logic                      ready_o,
	output logic                      res_req_o,
	output logic [`ROB_IDX_W-1:0]     res_tag_o,
	output logic [`XLEN-1:0]          res_data_o,
	output logic                      res_taken_o,
	output logic [`XLEN-1:0]          res_target_o
);

	localparam int N = `BR_RS_SIZE;
	localparam int IDX_W = $clog2(N);

	logic [N-1:0]                 ent_valid;
	logic [N-1:0][1:0]            ent_rdy, ent_rdy_w;
	logic [N-1:0][1:0][`XLEN-1:0] ent_src, ent_src_w;
	exec_pkg::op_e                ent_op [N];
	logic [`ROB_IDX_W-1:0]        ent_tag [N];
	logic [`XLEN-1:0]             ent_pc [N];
	logic [`XLEN-1:0]             ent_imm [N];
	logic [IDX_W-1:0]             ent_age [N];

	logic             free_found, sel_found, wr_en, issue, taken;
	logic [IDX_W-1:0] free_idx, sel_idx;
	logic [`XLEN-1:0] sel_a, sel_b, link, target;

	always_comb begin
		ent_rdy_w = ent_rdy;
		ent_src_w = ent_src;
		for (int i = 0; i < N; i++) begin
			for (int j = 0; j < 2; j++) begin
				if (!ent_rdy[i][j] && cdb_valid_i &&
						ent_src[i][j][`ROB_IDX_W-1:0] == cdb_tag_i) begin
					ent_rdy_w[i][j] = 1'b1;
					ent_src_w[i][j] = cdb_data_i;
				end
			end
		end
	end

	always_comb begin
		free_found = 1'b0;
		free_idx = '0;
		sel_found = 1'b0;
		sel_idx = '0;
		for (int i = N - 1; i >= 0; i--) begin
			if (!ent_valid[i]) begin
				free_found = 1'b1;
				free_idx = IDX_W'(i);
			end
		end
		for (int i = 0; i < N; i++) begin
			if (ent_valid[i] && (&ent_rdy_w[i]) &&
					(!sel_found || ent_age[i] > ent_age[sel_idx])) begin
				sel_found = 1'b1;
				sel_idx = IDX_W'(i);
			end
		end
	end

	assign ready_o = free_found;
	assign wr_en = wr_i && free_found && !flush_i;
	assign issue = sel_found && (!res_req_o || res_ack_i);
	assign sel_a = ent_src_w[sel_idx][0];
	assign sel_b = ent_src_w[sel_idx][1];

	always_comb begin
		case (ent_op[sel_idx])
			exec_pkg::OP_BEQ: taken = (sel_a == sel_b);
			exec_pkg::OP_BNE: taken = (sel_a != sel_b);
			exec_pkg::OP_BLT: taken = ($signed(sel_a) < $signed(sel_b));
			exec_pkg::OP_BGE: taken = ($signed(sel_a) >= $signed(sel_b));
			default:          taken = 1'b0;
		endcase
	end

	// Link value doubles as the fall-through target
	assign link = ent_pc[sel_idx] + `XLEN'(4);
	assign target = taken ? ent_pc[sel_idx] + ent_imm[sel_idx] : link;

	always_ff @(posedge clk) begin
		if (rst_i || flush_i) begin
			ent_valid <= '0;
			res_req_o <= 1'b0;
		end else begin
			if (issue)
				ent_valid[sel_idx] <= 1'b0;
			if (wr_en)
				ent_valid[free_idx] <= 1'b1;
			if (issue)
				res_req_o <= 1'b1;
			else if (res_ack_i)
				res_req_o <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		ent_rdy <= ent_rdy_w;
		ent_src <= ent_src_w;
		for (int i = 0; i < N; i++) begin
			if (ent_valid[i])
				ent_age[i] <= ent_age[i] + IDX_W'(wr_en)
					- IDX_W'(issue && ent_age[i] > ent_age[sel_idx]);
		end
		if (wr_en) begin
			ent_op[free_idx] <= op_i;
			ent_tag[free_idx] <= tag_i;
			ent_pc[free_idx] <= pc_i;
			ent_imm[free_idx] <= imm_i;
			ent_rdy[free_idx] <= src_ready_i;
			ent_src[free_idx] <= src_i;
			ent_age[free_idx] <= '0;
		end
		if (issue) begin
			res_tag_o <= ent_tag[sel_idx];
			res_data_o <= link;
			res_taken_o <= taken;
			res_target_o <= target;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/cdb_arbiter.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "exec_defs.svh"

module cdb_arbiter (
	input  logic                  clk,
	input  logic                  rst_i,
	input  logic                  flush_i,
	input  logic                  alu_req_i,
	input  logic [`ROB_IDX_W-1:0] alu_tag_i,
	input  logic [`XLEN-1:0]      alu_data_i,
	input  logic                  br_req_i,
	input  logic [`ROB_IDX_W-1:0] br_tag_i,
	input  logic [`XLEN-1:0]      br_data_i,
	input  logic                  br_taken_i,
	input  logic [`XLEN-1:0]      br_target_i,
	output logic                  alu_ack_o,
	output logic                  br_ack_o,
	output logic                  cdb_valid_o,
	output logic [`ROB_IDX_W-1:0] cdb_tag_o,
	output logic [`XLEN-1:0]      cdb_data_o,
	output logic                  br_resolved_o,
	output logic                  br_taken_o,
	output logic [`XLEN-1:0]      br_target_o
);

	// Branch first, ALU only when the branch unit is idle
	assign br_ack_o = br_req_i && !flush_i;
	assign alu_ack_o = alu_req_i && !br_req_i && !flush_i;

	always_ff @(posedge clk) begin
		if (rst_i || flush_i) begin
			cdb_valid_o <= 1'b0;
			br_resolved_o <= 1'b0;
			br_taken_o <= 1'b0;
		end else begin
			cdb_valid_o <= br_ack_o || alu_ack_o;
			br_resolved_o <= br_ack_o;
			br_taken_o <= br_ack_o && br_taken_i;
		end
	end

	always_ff @(posedge clk) begin
		if (br_ack_o) begin
			cdb_tag_o <= br_tag_i;
			cdb_data_o <= br_data_i;
			br_target_o <= br_target_i;
		end else if (alu_ack_o) begin
			cdb_tag_o <= alu_tag_i;
			cdb_data_o <= alu_data_i;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/exec_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "exec_defs.svh"

module exec_stage (
	input  logic                       clk,
	input  logic                       rst_i,
	input  logic                       disp_valid_i,
	input  exec_pkg::unit_e            disp_unit_i,
	input  exec_pkg::op_e              disp_op_i,
	input  logic [`ROB_IDX_W-1:0]      disp_tag_i,
	input  logic [1:0]                 disp_src_ready_i,
	input  logic [1:0][`XLEN-1:0]      disp_src_i,
	input  logic [`XLEN-1:0]           disp_pc_i,
	input  logic [`XLEN-1:0]           disp_imm_i,
	input  logic                       flush_i,
	input  logic [1:0]                 rob_rvalid_i,
	input  logic [1:0][`XLEN-1:0]      rob_rdata_i,
	output logic [1:0][`ROB_IDX_W-1:0] rob_raddr_o,
	output logic                       alu_ready_o,
	output logic                       br_ready_o,
	output logic                       cdb_valid_o,
	output logic [`ROB_IDX_W-1:0]      cdb_tag_o,
	output logic [`XLEN-1:0]           cdb_data_o,
	output logic                       br_resolved_o,
	output logic                       br_taken_o,
	output logic [`XLEN-1:0]           br_target_o
);

	logic [1:0]            cap_src_ready;
	logic [1:0][`XLEN-1:0] cap_src;
	logic                  alu_wr, br_wr;

	logic                  alu_req, alu_ack, br_req, br_ack, br_taken;
	logic [`ROB_IDX_W-1:0] alu_tag, br_tag;
	logic [`XLEN-1:0]      alu_data, br_data, br_target;

	assign alu_wr = disp_valid_i && disp_unit_i == exec_pkg::UNIT_ALU;
	assign br_wr = disp_valid_i && disp_unit_i == exec_pkg::UNIT_BR;

	operand_capture operand_capture_i (
		.src_ready_i  ( disp_src_ready_i ),
		.src_i        ( disp_src_i       ),
		.rob_rvalid_i ( rob_rvalid_i     ),
		.rob_rdata_i  ( rob_rdata_i      ),
		.cdb_valid_i  ( cdb_valid_o      ),
		.cdb_tag_i    ( cdb_tag_o        ),
		.cdb_data_i   ( cdb_data_o       ),
		.rob_raddr_o  ( rob_raddr_o      ),
		.src_ready_o  ( cap_src_ready    ),
		.src_o        ( cap_src          )
	);

	alu_rs alu_rs_i (
		.clk,
		.rst_i,
		.flush_i,
		.wr_i        ( alu_wr        ),
		.op_i        ( disp_op_i     ),
		.tag_i       ( disp_tag_i    ),
		.src_ready_i ( cap_src_ready ),
		.src_i       ( cap_src       ),
		.cdb_valid_i ( cdb_valid_o   ),
		.cdb_tag_i   ( cdb_tag_o     ),
		.cdb_data_i  ( cdb_data_o    ),
		.res_ack_i   ( alu_ack       ),
		.ready_o     ( alu_ready_o   ),
		.res_req_o   ( alu_req       ),
		.res_tag_o   ( alu_tag       ),
		.res_data_o  ( alu_data      )
	);

	branch_rs branch_rs_i (
		.clk,
		.rst_i,
		.flush_i,
		.wr_i         ( br_wr         ),
		.op_i         ( disp_op_i     ),
		.tag_i        ( disp_tag_i    ),
		.pc_i         ( disp_pc_i     ),
		.imm_i        ( disp_imm_i    ),
		.src_ready_i  ( cap_src_ready ),
		.src_i        ( cap_src       ),
		.cdb_valid_i  ( cdb_valid_o   ),
		.cdb_tag_i    ( cdb_tag_o     ),
		.cdb_data_i   ( cdb_data_o    ),
		.res_ack_i    ( br_ack        ),
		.ready_o      ( br_ready_o    ),
		.res_req_o    ( br_req        ),
		.res_tag_o    ( br_tag        ),
		.res_data_o   ( br_data       ),
		.res_taken_o  ( br_taken      ),
		.res_target_o ( br_target     )
	);

	cdb_arbiter cdb_arbiter_i (
		.clk,
		.rst_i,
		.flush_i,
		.alu_req_i     ( alu_req       ),
		.alu_tag_i     ( alu_tag       ),
		.alu_data_i    ( alu_data      ),
		.br_req_i      ( br_req        ),
		.br_tag_i      ( br_tag        ),
		.br_data_i     ( br_data       ),
		.br_taken_i    ( br_taken      ),
		.br_target_i   ( br_target     ),
		.alu_ack_o     ( alu_ack       ),
		.br_ack_o      ( br_ack        ),
		.cdb_valid_o   ( cdb_valid_o   ),
		.cdb_tag_o     ( cdb_tag_o     ),
		.cdb_data_o    ( cdb_data_o    ),
		.br_resolved_o ( br_resolved_o ),
		.br_taken_o    ( br_taken_o    ),
		.br_target_o   ( br_target_o   )
	);

endmodule

`default_nettype wire

// ==== verification/exec_stage_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "exec_defs.svh"

module exec_stage_tb;

	localparam int NTAGS = 1 << `ROB_IDX_W;
	localparam int NUM_OPS = 112;
	localparam int TIMEOUT_CYCLES = 64 * NUM_OPS + 200;
	localparam int SH_W = $clog2(`XLEN);

	logic                       clk;
	logic                       rst_i;
	logic                       disp_valid_i;
	exec_pkg::unit_e            disp_unit_i;
	exec_pkg::op_e              disp_op_i;
	logic [`ROB_IDX_W-1:0]      disp_tag_i;
	logic [1:0]                 disp_src_ready_i;
	logic [1:0][`XLEN-1:0]      disp_src_i;
	logic [`XLEN-1:0]           disp_pc_i;
	logic [`XLEN-1:0]           disp_imm_i;
	logic                       flush_i;
	logic [1:0]                 rob_rvalid_i;
	logic [1:0][`XLEN-1:0]      rob_rdata_i;
	logic [1:0][`ROB_IDX_W-1:0] rob_raddr_o;
	logic                       alu_ready_o;
	logic                       br_ready_o;
	logic                       cdb_valid_o;
	logic [`ROB_IDX_W-1:0]      cdb_tag_o;
	logic [`XLEN-1:0]           cdb_data_o;
	logic                       br_resolved_o;
	logic                       br_taken_o;
	logic [`XLEN-1:0]           br_target_o;

	// Reorder-buffer model and expected results, indexed by tag
	logic             rob_vld [NTAGS];
	logic [`XLEN-1:0] rob_val [NTAGS];
	logic             pending [NTAGS];
	logic             exp_br [NTAGS];
	logic [`XLEN-1:0] exp_data [NTAGS];
	logic             exp_taken [NTAGS];
	logic [`XLEN-1:0] exp_target [NTAGS];

	// Last CDB packet, waiting to be written into the ROB model
	logic                  commit_vld;
	logic [`ROB_IDX_W-1:0] commit_tag;
	logic [`XLEN-1:0]      commit_val;

	logic [31:0]           lfsr;
	logic [`ROB_IDX_W-1:0] next_tag;
	int                    alu_out, br_out;
	int                    err_cnt, fail_cnt, cycle_cnt;

	exec_stage exec_stage_i (.*);

	always #10 clk = ~clk;

	always_comb begin
		for (int i = 0; i < 2; i++) begin
			rob_rvalid_i[i] = rob_vld[rob_raddr_o[i]];
			rob_rdata_i[i] = rob_val[rob_raddr_o[i]];
		end
	end

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	// Returns {taken, target, data}
	function automatic logic [2*`XLEN:0] expect_result(input exec_pkg::op_e op,
			input logic [`XLEN-1:0] a, input logic [`XLEN-1:0] b,
			input logic [`XLEN-1:0] pc, input logic [`XLEN-1:0] imm);
		logic [`XLEN-1:0] data, target;
		logic             taken;
		data = '0;
		target = '0;
		taken = 1'b0;
		case (op)
			exec_pkg::OP_ADD: data = a + b;
			exec_pkg::OP_SUB: data = a - b;
			exec_pkg::OP_AND: data = a & b;
			exec_pkg::OP_OR:  data = a | b;
			exec_pkg::OP_XOR: data = a ^ b;
			exec_pkg::OP_SLL: data = a << b[SH_W-1:0];
			exec_pkg::OP_SRL: data = a >> b[SH_W-1:0];
			exec_pkg::OP_SLT: data = `XLEN'($signed(a) < $signed(b));
			exec_pkg::OP_BEQ: taken = (a == b);
			exec_pkg::OP_BNE: taken = (a != b);
			exec_pkg::OP_BLT: taken = ($signed(a) < $signed(b));
			exec_pkg::OP_BGE: taken = ($signed(a) >= $signed(b));
			default:          data = '0;
		endcase
		if (op >= exec_pkg::OP_BEQ) begin
			data = pc + `XLEN'(4);
			target = taken ? pc + imm : pc + `XLEN'(4);
		end
		return {taken, target, data};
	endfunction

	// ROB model write lands one cycle after its CDB packet
	task automatic step_cycle;
		@(posedge clk);
		#2;
		disp_valid_i = 1'b0;
		if (commit_vld) begin
			rob_vld[commit_tag] = 1'b1;
			rob_val[commit_tag] = commit_val;
			commit_vld = 1'b0;
		end
	endtask

	// op_sel below zero picks a random opcode, indep keeps both sources ready
	task automatic dispatch_op(input logic is_br, input int op_sel, input logic indep,
			input int gap);
		exec_pkg::op_e         op;
		logic [`ROB_IDX_W-1:0] cand;
		logic [`XLEN-1:0]      val [2];
		logic [`XLEN-1:0]      pc, imm;
		logic [11:0]           imm_raw;
		logic [2*`XLEN:0]      res;
		repeat (gap) step_cycle();
		while ((is_br ? !br_ready_o : !alu_ready_o) || pending[next_tag])
			step_cycle();
		if (is_br)
			op = exec_pkg::op_e'(4'(8 + rand_bits(2)));
		else if (op_sel >= 0)
			op = exec_pkg::op_e'(4'(op_sel));
		else
			op = exec_pkg::op_e'(4'(rand_bits(3)));
		for (int i = 0; i < 2; i++) begin
			cand = next_tag - `ROB_IDX_W'(1) - `ROB_IDX_W'(rand_bits(2));
			if (!indep && rand_bits(2) == 0 && (pending[cand] || rob_vld[cand])) begin
				disp_src_ready_i[i] = 1'b0;
				disp_src_i[i] = `XLEN'(cand);
				val[i] = exp_data[cand];
			end else begin
				disp_src_ready_i[i] = 1'b1;
				disp_src_i[i] = rand_bits(32);
				val[i] = disp_src_i[i];
			end
		end
		// Equal operands now and then so BEQ and BNE both go each way
		if (is_br && disp_src_ready_i == 2'b11 && rand_bits(1) == 1) begin
			disp_src_i[1] = disp_src_i[0];
			val[1] = val[0];
		end
		pc = rand_bits(32);
		pc[1:0] = 2'b00;
		imm_raw = 12'(rand_bits(12));
		imm = {{(`XLEN-12){imm_raw[11]}}, imm_raw};
		res = expect_result(op, val[0], val[1], pc, imm);
		exp_data[next_tag] = res[`XLEN-1:0];
		exp_target[next_tag] = res[2*`XLEN-1:`XLEN];
		exp_taken[next_tag] = res[2*`XLEN];
		exp_br[next_tag] = is_br;
		pending[next_tag] = 1'b1;
		rob_vld[next_tag] = 1'b0;
		if (is_br)
			br_out++;
		else
			alu_out++;
		disp_valid_i = 1'b1;
		disp_unit_i = exec_pkg::unit_e'(is_br);
		disp_op_i = op;
		disp_tag_i = next_tag;
		disp_pc_i = pc;
		disp_imm_i = imm;
		next_tag = next_tag + `ROB_IDX_W'(1);
		step_cycle();
	endtask

	task automatic apply_flush;
		flush_i = 1'b1;
		step_cycle();
		flush_i = 1'b0;
		// Whatever was still in flight is gone now
		for (int t = 0; t < NTAGS; t++)
			pending[t] = 1'b0;
		alu_out = 0;
		br_out = 0;
		@(negedge clk);
		if (!alu_ready_o || !br_ready_o) begin
			$display("a station was not ready in the cycle after the flush");
			fail_cnt++;
		end
		step_cycle();
	endtask

	// Compare process
	always @(negedge clk) begin
		logic [`ROB_IDX_W-1:0] t;
		int                    alu_occ, br_occ;
		if (!rst_i) begin
			t = cdb_tag_o;
			if (br_resolved_o && !cdb_valid_o) begin
				$display("error at %0t: branch resolved without a CDB packet", $time);
				err_cnt++;
			end
			if (cdb_valid_o && !pending[t]) begin
				$display("tag %0d appeared on the CDB while not in flight", t);
				fail_cnt++;
			end else if (cdb_valid_o) begin
				if (cdb_data_o != exp_data[t]) begin
					$display("error at %0t: tag %0d data %h, expected %h", $time, t,
						cdb_data_o, exp_data[t]);
					err_cnt++;
				end
				if (br_resolved_o != exp_br[t]) begin
					$display("error at %0t: tag %0d resolved flag %b, expected %b", $time,
						t, br_resolved_o, exp_br[t]);
					err_cnt++;
				end
				if (exp_br[t] && br_taken_o != exp_taken[t]) begin
					$display("error at %0t: tag %0d taken %b, expected %b", $time, t,
						br_taken_o, exp_taken[t]);
					err_cnt++;
				end
				if (exp_br[t] && br_target_o != exp_target[t]) begin
					$display("error at %0t: tag %0d target %h, expected %h", $time, t,
						br_target_o, exp_target[t]);
					err_cnt++;
				end
				pending[t] = 1'b0;
				commit_vld = 1'b1;
				commit_tag = t;
				commit_val = cdb_data_o;
				if (exp_br[t])
					br_out--;
				else
					alu_out--;
			end
			// Outstanding count minus the dispatch not yet written
			alu_occ = alu_out - ((disp_valid_i && disp_unit_i == exec_pkg::UNIT_ALU) ? 1 : 0);
			br_occ = br_out - ((disp_valid_i && disp_unit_i == exec_pkg::UNIT_BR) ? 1 : 0);
			if (alu_ready_o && alu_occ == `ALU_RS_SIZE + 1) begin
				$display("ALU station ready at %0t although all entries are taken", $time);
				fail_cnt++;
			end
			if (!alu_ready_o && alu_occ < `ALU_RS_SIZE) begin
				$display("ALU station not ready at %0t with free entries", $time);
				fail_cnt++;
			end
			if (br_ready_o && br_occ == `BR_RS_SIZE + 1) begin
				$display("branch station ready at %0t although all entries are taken", $time);
				fail_cnt++;
			end
			if (!br_ready_o && br_occ < `BR_RS_SIZE) begin
				$display("branch station not ready at %0t with free entries", $time);
				fail_cnt++;
			end
		end
	end

	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("timeout: run stopped after %0d cycles", cycle_cnt);
			$display("** FAIL **");
			$finish;
		end
	end

	initial begin
		clk = 1'b0;
		rst_i = 1'b1;
		flush_i = 1'b0;
		disp_valid_i = 1'b0;
		disp_unit_i = exec_pkg::UNIT_ALU;
		disp_op_i = exec_pkg::OP_ADD;
		disp_tag_i = '0;
		disp_src_ready_i = 2'b11;
		disp_src_i = '0;
		disp_pc_i = '0;
		disp_imm_i = '0;
		lfsr = 32'h5971_97aa;
		next_tag = '0;
		commit_vld = 1'b0;
		commit_tag = '0;
		commit_val = '0;
		alu_out = 0;
		br_out = 0;
		err_cnt = 0;
		fail_cnt = 0;
		cycle_cnt = 0;
		for (int t = 0; t < NTAGS; t++) begin
			rob_vld[t] = 1'b0;
			rob_val[t] = '0;
			pending[t] = 1'b0;
			exp_br[t] = 1'b0;
			exp_data[t] = '0;
			exp_taken[t] = 1'b0;
			exp_target[t] = '0;
		end
		repeat (4) @(posedge clk);
		#2;
		rst_i = 1'b0;
		step_cycle();

		// All eight ALU opcodes with ready sources
		for (int i = 0; i < 16; i++)
			dispatch_op(1'b0, i % 8, 1'b1, int'(rand_bits(2)));
		// Mixed units with dependencies and gaps
		for (int i = 0; i < 40; i++)
			dispatch_op(1'(rand_bits(2) == 0), -1, 1'b0, int'(rand_bits(2)));
		// No gaps, so the arbiter and stations back up
		for (int i = 0; i < 40; i++)
			dispatch_op(1'(rand_bits(1)), -1, 1'b0, 0);
		for (int i = 0; i < 6; i++)
			dispatch_op(1'(rand_bits(1)), -1, 1'b0, 0);
		apply_flush();
		for (int i = 0; i < 10; i++)
			dispatch_op(1'(rand_bits(2) == 0), -1, 1'b0, int'(rand_bits(1)));

		for (int c = 0; c < 400 && (alu_out + br_out) != 0; c++)
			step_cycle();
		for (int t = 0; t < NTAGS; t++) begin
			if (pending[t]) begin
				$display("tag %0d never appeared on the CDB", t);
				fail_cnt++;
			end
		end

		$display("value errors %0d, other failures %0d", err_cnt, fail_cnt);
		if (err_cnt == 0 && fail_cnt == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

// ==== exec_stage.f ====
+incdir+hdl
hdl/exec_pkg.sv
hdl/operand_capture.sv
hdl/alu_rs.sv
hdl/branch_rs.sv
hdl/cdb_arbiter.sv
hdl/exec_stage.sv
verification/exec_stage_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the exec_stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module exec_stage_tb \
	-f exec_stage.f -o exec_stage_sim
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

./obj_dir/exec_stage_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q '\*\* FAIL \*\*' sim.log; then
	echo "testbench reported a failure, see sim.log"
	exit 1
fi

exit 0
